/* source/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    localparam int ROB_TAG_W = 6;                // Slot index width, up to 64 slots

    // Instruction class, picks the completing unit and the commit action
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_MUL    = 2'd1,
        KIND_DIV    = 2'd2,
        KIND_BRANCH = 2'd3
    } rob_kind_e;

    typedef struct packed {
        logic        valid;                      // Dispatch strobe
        rob_kind_e   kind;
        logic        reg_write;                  // Writes a destination register
        logic [4:0]  dest;                       // Architectural destination
        logic [31:0] pc;
    } dispatch_t;

    typedef struct packed {
        logic        busy;                       // Slot allocated
        logic        ready;                      // Result has arrived
        rob_kind_e   kind;
        logic        reg_write;
        logic [4:0]  dest;
        logic [31:0] value;                      // Result, or branch target
        logic [31:0] pc;
        logic        mispredict;                 // Branch resolved the wrong way
    } rob_entry_t;

    typedef struct packed {
        logic                 valid;             // One retirement this cycle
        logic                 reg_write;         // Register file was written
        logic [4:0]           dest;
        logic [31:0]          value;
        logic [ROB_TAG_W-1:0] tag;               // Slot that retired
    } commit_t;

endpackage

`default_nettype wire

/* source/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Completion from ALU, multiplier or divider
    typedef struct packed {
        logic                          valid;    // Single-cycle strobe
        logic [rob_pkg::ROB_TAG_W-1:0] tag;      // ROB slot of the instruction
        logic [31:0]                   value;
    } exec_result_t;

    // Resolution from the branch unit
    typedef struct packed {
        logic                          valid;
        logic [rob_pkg::ROB_TAG_W-1:0] tag;
        logic                          mispredict; // Predicted path was wrong
        logic [31:0]                   target;     // Correct next PC
    } branch_result_t;

endpackage

`default_nettype wire

/* source/rob_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_ctrl #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           flush,
    input  wire rob_pkg::dispatch_t       dispatch,
    input  wire rob_pkg::rob_entry_t      head_entry,
    output logic                          alloc_we,
    output logic [rob_pkg::ROB_TAG_W-1:0] alloc_tag,
    output logic [rob_pkg::ROB_TAG_W-1:0] head_tag,
    output logic                          commit_en,
    output logic                          clear_all,
    output logic                          rob_full,
    output logic                          rob_empty
);
    import rob_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);

    logic [PTR_W-1:0] head_q;                     // Oldest slot
    logic [PTR_W-1:0] tail_q;                     // Next free slot
    logic [PTR_W:0]   count_q;                    // Occupied slots
    logic             mispredict_retire;

    assign rob_full  = (count_q == (PTR_W+1)'(ROB_DEPTH));
    assign rob_empty = (count_q == '0);

    // Oldest entry retires once its result is in, never during a flush
    assign commit_en = head_entry.busy && head_entry.ready && !flush;

    assign mispredict_retire = commit_en && (head_entry.kind == KIND_BRANCH)
                               && head_entry.mispredict;

    assign clear_all = flush || mispredict_retire;   // Recovery wins over allocation

    assign alloc_we  = dispatch.valid && !rob_full && !clear_all;
    assign alloc_tag = ROB_TAG_W'(tail_q);           // Tag is the slot index
    assign head_tag  = ROB_TAG_W'(head_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (clear_all) begin
            head_q  <= '0;                            // Restart from slot 0
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_we) begin
                tail_q <= tail_q + 1'b1;              // Wraps at power of two
            end
            if (commit_en) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_we, commit_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;          // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rob_store.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_store #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               alloc_we,
    input  wire [rob_pkg::ROB_TAG_W-1:0]      alloc_tag,
    input  wire rob_pkg::dispatch_t           dispatch,
    input  wire exec_pkg::exec_result_t       alu_result,
    input  wire exec_pkg::exec_result_t       mul_result,
    input  wire exec_pkg::exec_result_t       div_result,
    input  wire exec_pkg::branch_result_t     branch_result,
    input  wire [rob_pkg::ROB_TAG_W-1:0]      head_tag,
    input  wire                               commit_en,
    input  wire                               clear_all,
    output rob_pkg::rob_entry_t               head_entry
);
    import rob_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);

    rob_entry_t       entries [ROB_DEPTH];        // One entry per slot
    logic [PTR_W-1:0] alloc_idx;
    logic [PTR_W-1:0] head_idx;

    assign alloc_idx = alloc_tag[PTR_W-1:0];
    assign head_idx  = head_tag[PTR_W-1:0];

    assign head_entry = entries[head_idx];        // Oldest entry, read combinationally

    // Strobe addressed to slot idx
    function automatic logic tag_hit(input logic v, input logic [ROB_TAG_W-1:0] t,
                                     input int idx);
        tag_hit = v && (t == ROB_TAG_W'(idx));
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            // Later writes win, so div > mul > alu > branch on a shared tag
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (entries[i].busy) begin                 // Stale tags are dropped
                    if (tag_hit(branch_result.valid, branch_result.tag, i)) begin
                        entries[i].ready      <= 1'b1;
                        entries[i].value      <= branch_result.target; // Keep target
                        entries[i].mispredict <= branch_result.mispredict;
                    end
                    if (tag_hit(alu_result.valid, alu_result.tag, i)) begin
                        entries[i].ready <= 1'b1;
                        entries[i].value <= alu_result.value;
                    end
                    if (tag_hit(mul_result.valid, mul_result.tag, i)) begin
                        entries[i].ready <= 1'b1;
                        entries[i].value <= mul_result.value;
                    end
                    if (tag_hit(div_result.valid, div_result.tag, i)) begin
                        entries[i].ready <= 1'b1;
                        entries[i].value <= div_result.value;
                    end
                end
            end
            if (alloc_we) begin
                entries[alloc_idx] <= '{busy:       1'b1,
                                        ready:      1'b0,    // Waits for its unit
                                        kind:       dispatch.kind,
                                        reg_write:  dispatch.reg_write,
                                        dest:       dispatch.dest,
                                        value:      32'd0,
                                        pc:         dispatch.pc,
                                        mispredict: 1'b0};
            end
            if (commit_en) begin
                entries[head_idx] <= '0;                   // Free retired slot
            end
            if (clear_all) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    entries[i] <= '0;                      // Drop every slot
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          commit_en,
    input  wire rob_pkg::rob_entry_t     head_entry,
    input  wire [rob_pkg::ROB_TAG_W-1:0] head_tag,
    output rob_pkg::commit_t             commit,
    output logic                         rf_we,
    output logic [4:0]                   rf_waddr,
    output logic [31:0]                  rf_wdata,
    output logic                         redirect_valid,
    output logic [31:0]                  redirect_pc
);
    import rob_pkg::*;

    logic    do_write;                            // Retirement updates the register file
    logic    do_redirect;                         // Retirement of a wrong-path branch
    commit_t commit_q;                            // Commit record, valid bit included

    assign do_write = commit_en && head_entry.reg_write
                      && (head_entry.kind != KIND_BRANCH) && (head_entry.dest != 5'd0);
    assign do_redirect = commit_en && (head_entry.kind == KIND_BRANCH)
                         && head_entry.mispredict;

    // Write lands on the same edge that raises commit.valid
    assign rf_we    = do_write;
    assign rf_waddr = head_entry.dest;
    assign rf_wdata = head_entry.value;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_q       <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= 32'd0;
        end else begin
            commit_q.valid <= commit_en;          // One cycle per retirement
            redirect_valid <= do_redirect;
            if (commit_en) begin
                commit_q.reg_write <= do_write;   // Low for branches and x0
                commit_q.dest      <= head_entry.dest;
                commit_q.value     <= head_entry.value;
                commit_q.tag       <= head_tag;
            end
            if (do_redirect) begin
                redirect_pc <= head_entry.value;  // Stored branch target
            end
        end
    end

    assign commit = commit_q;

endmodule

`default_nettype wire

/* source/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  wire        clk,
    input  wire        rst,
    input  wire        we,
    input  wire [4:0]  waddr,
    input  wire [31:0] wdata,
    input  wire [4:0]  raddr,
    output logic [31:0] rdata
);

    logic [31:0] regs [32];                       // Committed architectural state

    // Decode-stage operand read, no clock
    assign rdata = regs[raddr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (waddr != 5'd0)) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* source/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           flush,
    input  wire rob_pkg::dispatch_t       dispatch,
    input  wire exec_pkg::exec_result_t   alu_result,
    input  wire exec_pkg::exec_result_t   mul_result,
    input  wire exec_pkg::exec_result_t   div_result,
    input  wire exec_pkg::branch_result_t branch_result,
    input  wire [4:0]                     rf_raddr,
    output logic [rob_pkg::ROB_TAG_W-1:0] dispatch_tag,
    output logic                          rob_full,
    output logic                          rob_empty,
    output rob_pkg::commit_t              commit,
    output logic                          redirect_valid,
    output logic [31:0]                   redirect_pc,
    output logic [31:0]                   rf_rdata
);
    import rob_pkg::*;

    logic                 alloc_we;
    logic [ROB_TAG_W-1:0] head_tag;
    logic                 commit_en;
    logic                 clear_all;
    rob_entry_t           head_entry;             // Oldest slot contents
    logic                 rf_we;
    logic [4:0]           rf_waddr;
    logic [31:0]          rf_wdata;

    rob_ctrl #(.ROB_DEPTH(ROB_DEPTH)) u_ctrl (
        .clk(clk), .rst(rst), .flush(flush),
        .dispatch(dispatch), .head_entry(head_entry),
        .alloc_we(alloc_we), .alloc_tag(dispatch_tag),   // Tag goes back to dispatch
        .head_tag(head_tag), .commit_en(commit_en), .clear_all(clear_all),
        .rob_full(rob_full), .rob_empty(rob_empty)
    );

    rob_store #(.ROB_DEPTH(ROB_DEPTH)) u_store (
        .clk(clk), .rst(rst),
        .alloc_we(alloc_we), .alloc_tag(dispatch_tag), .dispatch(dispatch),
        .alu_result(alu_result), .mul_result(mul_result), .div_result(div_result),
        .branch_result(branch_result),
        .head_tag(head_tag), .commit_en(commit_en), .clear_all(clear_all),
        .head_entry(head_entry)
    );

    rob_commit u_commit (
        .clk(clk), .rst(rst), .commit_en(commit_en),
        .head_entry(head_entry), .head_tag(head_tag), .commit(commit),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    arch_regfile u_regfile (
        .clk(clk), .rst(rst),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr(rf_raddr), .rdata(rf_rdata)
    );

endmodule

`default_nettype wire

/* testbench/tb_rob.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob;
    import rob_pkg::*;
    import exec_pkg::*;

    localparam int NUM_ROWS    = 23;
    localparam int HALF_PERIOD = 50;               // 100 ns clock
    localparam int DEPTH       = 8;                // ROB slots in the DUT

    typedef struct packed {
        rob_kind_e   kind;
        logic [4:0]  dest;
        logic        reg_write;
        logic [31:0] value;                        // Result, or target for a branch
        int          delay;                        // Completion order key
        logic        mispredict;
    } row_t;

    typedef struct packed {
        logic [4:0]           dest;
        logic                 reg_write;           // Register file should change
        logic [31:0]          value;
        logic                 redirect;            // Wrong-path branch
        logic [ROB_TAG_W-1:0] tag;                 // Slot the entry was given
    } exp_t;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    dispatch_t            dispatch;
    exec_result_t         alu_result;
    exec_result_t         mul_result;
    exec_result_t         div_result;
    branch_result_t       branch_result;
    logic [4:0]           rf_raddr;
    logic [ROB_TAG_W-1:0] dispatch_tag;
    logic                 rob_full;
    logic                 rob_empty;
    commit_t              commit;
    logic                 redirect_valid;
    logic [31:0]          redirect_pc;
    logic [31:0]          rf_rdata;

    row_t                 tbl [NUM_ROWS];          // Stimulus table
    logic [ROB_TAG_W-1:0] tags [NUM_ROWS];         // Tag handed out per row
    exp_t                 exp_q [$];               // Scoreboard, dispatch order
    logic [31:0]          exp_regs [32];           // Register file model
    int                   exp_tail;                // Model of the next free slot
    bit                   exp_on;
    int                   seed;
    int                   errors;
    int                   checks;
    int                   errs_before;

    rob_top #(.ROB_DEPTH(DEPTH)) DUT (
        .clk(clk), .rst(rst), .flush(flush), .dispatch(dispatch),
        .alu_result(alu_result), .mul_result(mul_result), .div_result(div_result),
        .branch_result(branch_result), .rf_raddr(rf_raddr),
        .dispatch_tag(dispatch_tag), .rob_full(rob_full), .rob_empty(rob_empty),
        .commit(commit), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .rf_rdata(rf_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        repeat (NUM_ROWS * 50 + 200) @(posedge clk);    // Budget per table row
        $display("Timeout: run did not finish within %0d cycles", NUM_ROWS * 50 + 200);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    task automatic set_row(input int i, input rob_kind_e k, input int d, input bit rw,
                           input logic [31:0] v, input int dl, input bit m);
        tbl[i] = '{k, 5'(d), rw, v, dl, m};
    endtask

    task automatic clear_strobes;
        alu_result    = '0;
        mul_result    = '0;
        div_result    = '0;
        branch_result = '0;
    endtask

    task automatic dispatch_rows(input int first, input int last);
        bit   squash;
        exp_t e;
        squash = 1'b0;
        for (int r = first; r <= last; r++) begin
            @(negedge clk);
            dispatch = '{valid: 1'b1, kind: tbl[r].kind, reg_write: tbl[r].reg_write,
                         dest: tbl[r].dest, pc: 32'h1000 + 32'(r * 4)};
            check("dispatch_tag", 32'(dispatch_tag), 32'(exp_tail));
            tags[r]     = dispatch_tag;            // Tail slot, taken at next edge
            e.dest      = tbl[r].dest;
            e.reg_write = tbl[r].reg_write && (tbl[r].dest != 5'd0)
                          && (tbl[r].kind != KIND_BRANCH);
            e.value     = tbl[r].value;
            e.redirect  = (tbl[r].kind == KIND_BRANCH) && tbl[r].mispredict;
            e.tag       = ROB_TAG_W'(exp_tail);
            exp_tail    = (exp_tail + 1) % DEPTH;  // Slots are handed out in a ring
            if (exp_on && !squash) exp_q.push_back(e);
            if (e.redirect) squash = 1'b1;         // Younger rows on wrong path
        end
        @(negedge clk);
        dispatch.valid = 1'b0;
    endtask

    // One completion per cycle, ordered by delay, ties by row
    task automatic complete_rows(input int first, input int last);
        for (int t = 0; t < 16; t++) begin
            for (int r = first; r <= last; r++) begin
                if (tbl[r].delay == t) begin
                    @(negedge clk);
                    clear_strobes();
                    case (tbl[r].kind)
                        KIND_ALU: alu_result = '{valid: 1'b1, tag: tags[r], value: tbl[r].value};
                        KIND_MUL: mul_result = '{valid: 1'b1, tag: tags[r], value: tbl[r].value};
                        KIND_DIV: div_result = '{valid: 1'b1, tag: tags[r], value: tbl[r].value};
                        default:  branch_result = '{valid: 1'b1, tag: tags[r],
                                                    mispredict: tbl[r].mispredict,
                                                    target: tbl[r].value};
                    endcase
                end
            end
        end
        @(negedge clk);
        clear_strobes();
    endtask

    task automatic wait_drain;
        while (exp_q.size() != 0) @(posedge clk);     // Monitor pops on falling edges
        @(negedge clk);
    endtask

    task automatic check_regs;
        @(negedge clk);
        for (int i = 0; i < 32; i++) begin
            rf_raddr = 5'(i);
            #1;                                        // Async read settles
            check($sformatf("rf_rdata[x%0d]", i), rf_rdata, exp_regs[i]);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - errs_before);
        errs_before = errors;
    endtask

    // Commit monitor against the scoreboard
    always @(negedge clk) begin
        exp_t e;
        if (!rst && commit.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected commit of slot %0d at %0t with nothing left to retire",
                         commit.tag, $time);
            end else begin
                e = exp_q.pop_front();
                check("commit.dest", 32'(commit.dest), 32'(e.dest));
                check("commit.value", commit.value, e.value);
                check("commit.reg_write", 32'(commit.reg_write), 32'(e.reg_write));
                check("commit.tag", 32'(commit.tag), 32'(e.tag));
                check("redirect_valid", 32'(redirect_valid), 32'(e.redirect));
                if (e.redirect) check("redirect_pc", redirect_pc, e.value);
                if (e.redirect) exp_tail = 0;          // Pointers restart at slot 0
                if (e.reg_write) exp_regs[e.dest] = e.value;
            end
        end
    end

    initial begin
        seed        = 32'h8fb35d01;
        errors      = 0;
        checks      = 0;
        errs_before = 0;
        exp_tail    = 0;
        exp_on      = 1'b1;
        rst         = 1'b1;
        flush       = 1'b0;
        dispatch    = '0;
        rf_raddr    = '0;
        clear_strobes();
        for (int i = 0; i < 32; i++) exp_regs[i] = 32'd0;

        set_row(0, KIND_ALU, 3, 1'b1, 32'h0000_0011, 5, 1'b0);   // Reverse completion
        set_row(1, KIND_MUL, 5, 1'b1, 32'h0000_0222, 4, 1'b0);
        set_row(2, KIND_DIV, 3, 1'b1, 32'h0000_3333, 3, 1'b0);   // Overwrites x3
        set_row(3, KIND_ALU, 0, 1'b1, 32'h0000_4444, 2, 1'b0);   // x0 target
        set_row(4, KIND_ALU, 7, 1'b0, 32'h0000_5555, 1, 1'b0);   // No register write
        set_row(5, KIND_MUL, 9, 1'b1, 32'h0000_6666, 0, 1'b0);
        for (int r = 6; r <= 14; r++) set_row(r, KIND_ALU, r + 4, 1'b1, 32'hA000_0000 + 32'(r),
                                              14 - r, 1'b0);
        set_row(15, KIND_DIV, 20, 1'b1, 32'hB000_0015, $random(seed) & 7, 1'b0);
        set_row(16, KIND_BRANCH, 0, 1'b0, 32'h0000_2000, $random(seed) & 7, 1'b0);
        set_row(17, KIND_MUL, 21, 1'b1, 32'hB000_0017, $random(seed) & 7, 1'b0);
        set_row(18, KIND_BRANCH, 0, 1'b0, 32'h0000_3000, $random(seed) & 7, 1'b1);
        set_row(19, KIND_ALU, 22, 1'b1, 32'hB000_0019, $random(seed) & 7, 1'b0); // Squashed
        for (int r = 20; r <= 22; r++) set_row(r, KIND_ALU, r + 3, 1'b1, 32'hC000_0000 + 32'(r),
                                               22 - r, 1'b0);

        repeat (8) @(negedge clk);
        rst = 1'b0;

        check("rob_empty", 32'(rob_empty), 32'd1);
        check("rob_full", 32'(rob_full), 32'd0);
        check("commit.valid", 32'(commit.valid), 32'd0);
        check("redirect_valid", 32'(redirect_valid), 32'd0);
        check_regs();
        end_test("reset");

        dispatch_rows(0, 5);
        complete_rows(0, 5);
        wait_drain();
        check_regs();
        check("rob_empty", 32'(rob_empty), 32'd1);
        end_test("reverse completion");

        dispatch_rows(6, 13);
        check("rob_full", 32'(rob_full), 32'd1);
        complete_rows(6, 6);                           // Head only
        while (exp_q.size() != 7) @(posedge clk);
        @(negedge clk);
        check("rob_full", 32'(rob_full), 32'd0);
        dispatch_rows(14, 14);
        check("rob_full", 32'(rob_full), 32'd1);       // Freed slot refilled
        complete_rows(7, 14);
        wait_drain();
        check_regs();
        end_test("full buffer");

        dispatch_rows(15, 19);
        complete_rows(15, 19);
        wait_drain();
        repeat (4) @(negedge clk);
        check("rob_empty", 32'(rob_empty), 32'd1);
        check_regs();
        end_test("branch recovery");

        exp_on = 1'b0;                                 // Nothing here may retire
        dispatch_rows(20, 22);
        complete_rows(21, 22);                         // Head stays pending
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        exp_tail = 0;
        check("rob_empty", 32'(rob_empty), 32'd1);
        complete_rows(20, 20);                         // Stale tag after flush
        repeat (4) @(negedge clk);
        check_regs();
        end_test("flush");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/rob_pkg.sv
source/exec_pkg.sv
source/rob_ctrl.sv
source/rob_store.sv
source/rob_commit.sv
source/arch_regfile.sv
source/rob_top.sv
testbench/tb_rob.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rob -f tb.f -o sim_rob
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rob > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
